//--- verilog.f
hdl/cache_pkg.sv
hdl/mem_pkg.sv
hdl/line_cache.sv
hdl/mem_arbiter.sv
hdl/backing_store.sv
hdl/cache_subsystem_top.sv
bench/cache_properties.sv
bench/cache_tb.sv

//--- run.sh
#!/bin/sh
# Build the cache testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal --top-module cache_tb \
    -f verilog.f -o cache_sim > build.log 2>&1 \
    && ./obj_dir/cache_sim > sim.log 2>&1 \
    || echo "test failed" >> sim.log

grep -q "test failed" sim.log \
    && { echo "FAIL (see sim.log and build.log)"; exit 1; } \
    || { echo "PASS"; exit 0; }

//--- bench/cache_tb.sv
//################################################
// Directed testbench for the two-port cache subsystem
// Checks read data against a per-address scoreboard
//################################################
`timescale 1ns/1ps

module cache_tb;
    import cache_pkg::*;
    import mem_pkg::*;

    localparam int N_PORTS = 2;
    localparam int LIMIT   = 50;  // Cycles allowed for one request
    localparam int HIT     = 1;
    localparam int MISS    = 2;

    logic               clk;
    logic               rst;
    cache_addr_t        addr [N_PORTS];
    logic [DATA_W-1:0]  write_data [N_PORTS];
    logic [N_PORTS-1:0] write_enable;
    logic [N_PORTS-1:0] read_enable;
    logic [DATA_W-1:0]  read_data [N_PORTS];
    logic [N_PORTS-1:0] hit;
    logic [N_PORTS-1:0] miss;
    logic [N_PORTS-1:0] done;
    logic [N_PORTS-1:0] busy;

    logic [DATA_W-1:0]  sb [MEM_WORDS];  // Last value written per address
    logic [31:0]        lfsr;
    int                 errors;
    int                 timeouts;

    cache_subsystem_top #(
        .N_PORTS (N_PORTS)
    ) dut (
        .clk          (clk),
        .rst          (rst),
        .addr         (addr),
        .write_data   (write_data),
        .write_enable (write_enable),
        .read_enable  (read_enable),
        .read_data    (read_data),
        .hit          (hit),
        .miss         (miss),
        .done         (done),
        .busy         (busy)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};  // One step per bit
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic strobe(input int p, input logic wr, input logic [ADDR_W-1:0] a,
                          input logic [DATA_W-1:0] d);
        addr[p]         = a;
        write_data[p]   = d;
        write_enable[p] = wr;
        read_enable[p]  = !wr;
    endtask

    task automatic release_strobes();
        write_enable = '0;
        read_enable  = '0;
    endtask

    // Done pulses are caught since sampling is once per cycle
    task automatic wait_done(input logic [N_PORTS-1:0] mask);
        logic [N_PORTS-1:0] seen;
        int                 n;
        seen = done & mask;
        n    = 0;
        while (seen != mask && n < LIMIT) begin
            tick();
            n++;
            seen = seen | (done & mask);
        end
        if (seen != mask) begin
            timeouts++;
            $display("Timeout: no done on port mask %b within %0d cycles", mask, LIMIT);
        end
    endtask

    task automatic check_data(input int p, input logic [ADDR_W-1:0] a);
        assert (read_data[p] == sb[a]) else begin
            errors++;
            $display("Error: read_data[%0d] at 0x%03h is 0x%03h, expected 0x%03h",
                     p, a, read_data[p], sb[a]);
        end
    endtask

    task automatic write_port(input int p, input logic [ADDR_W-1:0] a,
                              input logic [DATA_W-1:0] d);
        strobe(p, 1'b1, a, d);
        sb[a] = d;
        tick();
        release_strobes();
        assert (busy[p]) else begin
            errors++;
            $display("Error: busy[%0d] is 0x%h after a write strobe, expected 0x1", p, busy[p]);
        end
        wait_done(N_PORTS'(1) << p);
    endtask

    task automatic read_port(input int p, input logic [ADDR_W-1:0] a, input int kind);
        strobe(p, 1'b0, a, '0);
        tick();
        release_strobes();
        if (kind == HIT) begin
            assert (hit[p] && !miss[p] && done[p]) else begin
                errors++;
                $display("Error: port %0d hit 0x%h miss 0x%h done 0x%h, expected a hit",
                         p, hit[p], miss[p], done[p]);
            end
        end else if (kind == MISS) begin
            assert (miss[p] && !hit[p] && busy[p]) else begin
                errors++;
                $display("Error: port %0d hit 0x%h miss 0x%h busy 0x%h, expected a miss",
                         p, hit[p], miss[p], busy[p]);
            end
        end
        wait_done(N_PORTS'(1) << p);
        check_data(p, a);
    endtask

    initial begin
        logic [31:0]       v;
        logic [ADDR_W-1:0] x;
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] b;
        logic [DATA_W-1:0] d0;
        errors   = 0;
        timeouts = 0;
        lfsr     = 32'h4c28_45e6;
        sb       = '{default: '0};
        rst      = 1'b1;
        release_strobes();
        for (int p = 0; p < N_PORTS; p++) begin
            addr[p]       = '0;
            write_data[p] = '0;
        end
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        tick();

        // Write then hit on port 0, then a cold miss on port 1
        take_bits(ADDR_W, v);
        x = v[ADDR_W-1:0];
        take_bits(DATA_W, v);
        write_port(0, x, v[DATA_W-1:0]);
        read_port(0, x, HIT);
        read_port(1, x, MISS);

        // Two tags fighting for one line on port 0
        a = x ^ 9'h001;
        b = a ^ 9'h120;
        take_bits(DATA_W, v);
        write_port(1, a, v[DATA_W-1:0]);
        take_bits(DATA_W, v);
        write_port(1, b, v[DATA_W-1:0]);
        for (int i = 0; i < 2; i++) begin
            read_port(0, a, MISS);
            read_port(0, b, MISS);
        end

        // Port 0 write must knock x out of port 1
        read_port(1, x, HIT);
        take_bits(DATA_W, v);
        write_port(0, x, v[DATA_W-1:0]);
        read_port(1, x, MISS);

        // Both ports at once, then cross reads
        for (int i = 0; i < 8; i++) begin
            take_bits(ADDR_W, v);
            a = v[ADDR_W-1:0];
            b = a ^ 9'h100;  // Same index, other tag
            take_bits(DATA_W, v);
            d0 = v[DATA_W-1:0];
            take_bits(DATA_W, v);
            strobe(0, 1'b1, a, d0);
            strobe(1, 1'b1, b, v[DATA_W-1:0]);
            sb[a] = d0;
            sb[b] = v[DATA_W-1:0];
            tick();
            release_strobes();
            wait_done(2'b11);
            strobe(0, 1'b0, b, '0);
            strobe(1, 1'b0, a, '0);
            tick();
            release_strobes();
            wait_done(2'b11);
            check_data(0, b);
            check_data(1, a);
        end

        $display("Finished with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- bench/cache_properties.sv
//################################################
// Bus and pulse properties, bound into the arbiter
// and into every cache instance
//################################################
`timescale 1ns/1ps

module cache_properties #(
    parameter int N = 1
) (
    input logic         clk,
    input logic         rst,
    input logic [N-1:0] grant,
    input logic         ack,
    input logic         hit,
    input logic         miss,
    input logic         busy
);

    // At most one owner of the store bus
    grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
        else $error("grant is not one-hot or zero: %b", grant);

    ack_granted: assert property (@(posedge clk) disable iff (rst) ack |-> (grant != '0))
        else $error("ack seen without a held grant");

    hit_miss_excl: assert property (@(posedge clk) disable iff (rst) !(hit && miss))
        else $error("hit and miss pulsed in the same cycle");

    // Nothing can be pending right after reset
    busy_after_reset: assert property (@(posedge clk) $fell(rst) |=> !busy)
        else $error("busy high one cycle after reset release");

endmodule

bind mem_arbiter cache_properties #(
    .N (N_PORTS)
) u_arb_props (
    .clk   (clk),
    .rst   (rst),
    .grant (grant),
    .ack   (ack),
    .hit   (1'b0),
    .miss  (1'b0),
    .busy  (1'b0)
);

// Bus ownership is covered at the arbiter
bind line_cache cache_properties #(
    .N (1)
) u_cache_props (
    .clk   (clk),
    .rst   (rst),
    .grant (1'b0),
    .ack   (1'b0),
    .hit   (hit),
    .miss  (miss),
    .busy  (busy)
);

//--- hdl/cache_subsystem_top.sv
//################################################
// Two client caches sharing one backing store
//################################################
`timescale 1ns/1ps

module cache_subsystem_top #(
    parameter int N_PORTS = 2
) (
    input  logic                         clk,
    input  logic                         rst,
    input  cache_pkg::cache_addr_t       addr [N_PORTS],
    input  logic [cache_pkg::DATA_W-1:0] write_data [N_PORTS],
    input  logic [N_PORTS-1:0]           write_enable,
    input  logic [N_PORTS-1:0]           read_enable,
    output logic [cache_pkg::DATA_W-1:0] read_data [N_PORTS],
    output logic [N_PORTS-1:0]           hit,
    output logic [N_PORTS-1:0]           miss,
    output logic [N_PORTS-1:0]           done,
    output logic [N_PORTS-1:0]           busy
);
    import cache_pkg::*;
    import mem_pkg::*;

    mem_req_t              reqs [N_PORTS];
    logic [N_PORTS-1:0]    want;
    logic [N_PORTS-1:0]    grant;
    mem_req_t              bus_req;
    logic                  bus_valid;
    logic                  ack;
    logic [DATA_W-1:0]     rdata;
    logic                  snoop_valid;
    logic [ADDR_W-1:0]     snoop_addr;
    logic [N_PORTS-1:0]    port_ack;
    logic [DATA_W-1:0]     port_rdata [N_PORTS];

    for (genvar p = 0; p < N_PORTS; p++) begin : g_port
        assign port_ack[p]   = ack & grant[p];
        assign port_rdata[p] = grant[p] ? rdata : '0;  // Only the owner sees data

        line_cache u_cache (
            .clk          (clk),
            .rst          (rst),
            .addr         (addr[p]),
            .write_data   (write_data[p]),
            .write_enable (write_enable[p]),
            .read_enable  (read_enable[p]),
            .mem_ack      (port_ack[p]),
            .mem_rdata    (port_rdata[p]),
            .snoop_valid  (snoop_valid),
            .snoop_addr   (snoop_addr),
            .granted      (grant[p]),
            .read_data    (read_data[p]),
            .hit          (hit[p]),
            .miss         (miss[p]),
            .done         (done[p]),
            .busy         (busy[p]),
            .mem_want     (want[p]),
            .mem_req      (reqs[p])
        );
    end

    mem_arbiter #(
        .N_PORTS (N_PORTS)
    ) u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .want        (want),
        .reqs        (reqs),
        .ack         (ack),
        .grant       (grant),
        .bus_req     (bus_req),
        .bus_valid   (bus_valid),
        .snoop_valid (snoop_valid),
        .snoop_addr  (snoop_addr)
    );

    backing_store u_store (
        .clk       (clk),
        .rst       (rst),
        .bus_req   (bus_req),
        .bus_valid (bus_valid),
        .ack       (ack),
        .rdata     (rdata)
    );

endmodule

//--- hdl/backing_store.sv
//################################################
// 512-word shared memory behind the arbiter
// Acks each granted request once, one cycle late
//################################################
`timescale 1ns/1ps

module backing_store (
    input  logic                         clk,
    input  logic                         rst,
    input  mem_pkg::mem_req_t            bus_req,
    input  logic                         bus_valid,
    output logic                         ack,
    output logic [cache_pkg::DATA_W-1:0] rdata
);
    import mem_pkg::*;
    import cache_pkg::*;

    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic              take;

    // Valid stays up through the ack cycle, so skip that one
    assign take = bus_valid && !ack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack   <= 1'b0;
            rdata <= '0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            ack <= take;
            if (take) begin
                if (bus_req.write) begin
                    mem[bus_req.addr] <= bus_req.wdata;
                end
                rdata <= mem[bus_req.addr];  // Ignored by a writer
            end
        end
    end

endmodule

//--- hdl/mem_arbiter.sv
//################################################
// Round-robin owner of the backing-store bus
// Also broadcasts each accepted write as a snoop
//################################################
`timescale 1ns/1ps

module mem_arbiter #(
    parameter int N_PORTS = 2
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [N_PORTS-1:0]         want,
    input  mem_pkg::mem_req_t          reqs [N_PORTS],
    input  logic                       ack,
    output logic [N_PORTS-1:0]         grant,
    output mem_pkg::mem_req_t          bus_req,
    output logic                       bus_valid,
    output logic                       snoop_valid,
    output logic [mem_pkg::ADDR_W-1:0] snoop_addr
);
    localparam int PTR_W = $clog2(N_PORTS);

    logic [PTR_W-1:0] last;   // Port served most recently
    logic [PTR_W-1:0] owner;  // Port holding the grant
    logic [PTR_W-1:0] next_idx;
    logic             next_found;

    // First asking port after the last one served
    always_comb begin
        int cand;
        next_found = 1'b0;
        next_idx   = last;
        for (int k = 1; k <= N_PORTS; k++) begin
            cand = (int'(last) + k) % N_PORTS;
            if (!next_found && want[cand]) begin
                next_found = 1'b1;
                next_idx   = PTR_W'(cand);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant <= '0;
            owner <= '0;
            last  <= PTR_W'(N_PORTS - 1);  // Port 0 goes first
        end else if (grant != '0) begin
            if (ack) begin
                grant <= '0;
                last  <= owner;
            end
        end else if (next_found) begin
            grant <= N_PORTS'(1) << next_idx;
            owner <= next_idx;
        end
    end

    assign bus_req   = reqs[owner];
    assign bus_valid = |grant;

    // One-cycle broadcast, same cycle as the ack
    assign snoop_valid = ack && bus_req.write;
    assign snoop_addr  = bus_req.addr;

endmodule

//--- hdl/line_cache.sv
//################################################
// Direct-mapped write-through cache for one client
// Read misses fill from the shared store, peers snoop
//################################################
`timescale 1ns/1ps

module line_cache (
    input  logic                         clk,
    input  logic                         rst,
    input  cache_pkg::cache_addr_t       addr,
    input  logic [cache_pkg::DATA_W-1:0] write_data,
    input  logic                         write_enable,
    input  logic                         read_enable,
    input  logic                         mem_ack,
    input  logic [cache_pkg::DATA_W-1:0] mem_rdata,
    input  logic                         snoop_valid,
    input  logic [mem_pkg::ADDR_W-1:0]   snoop_addr,
    input  logic                         granted,
    output logic [cache_pkg::DATA_W-1:0] read_data,
    output logic                         hit,
    output logic                         miss,
    output logic                         done,
    output logic                         busy,
    output logic                         mem_want,
    output mem_pkg::mem_req_t            mem_req
);
    import cache_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_FILL,  // Waiting for the line fill
        S_WT     // Waiting for the write to land
    } state_t;

    state_t state;

    logic [TAG_W-1:0]  tags [N_LINES];
    logic [DATA_W-1:0] data [N_LINES];
    logic [N_LINES-1:0] valid;

    cache_addr_t fill_view;
    cache_addr_t snoop_view;
    logic        lookup_hit;
    logic        snoop_hit;
    logic        start_write;
    logic        start_fill;
    logic        fill_done;

    assign fill_view  = mem_req.addr;  // Outstanding fill address
    assign snoop_view = snoop_addr;

    assign lookup_hit = valid[addr.index] && (tags[addr.index] == addr.tag);

    // The port being served wrote this itself, so it keeps its line
    assign snoop_hit = snoop_valid && !granted && valid[snoop_view.index] &&
                       (tags[snoop_view.index] == snoop_view.tag);

    assign start_write = (state == S_IDLE) && write_enable;
    assign start_fill  = (state == S_IDLE) && !write_enable && read_enable && !lookup_hit;
    assign fill_done   = (state == S_FILL) && mem_ack;

    assign busy     = (state != S_IDLE);
    assign mem_want = (state != S_IDLE);  // Held until the ack

    // Line storage and the outgoing request
    always_ff @(posedge clk) begin
        if (start_write) begin
            tags[addr.index] <= addr.tag;
            data[addr.index] <= write_data;
            mem_req.addr     <= addr;
            mem_req.wdata    <= write_data;
            mem_req.write    <= 1'b1;
        end else if (start_fill) begin
            mem_req.addr  <= addr;
            mem_req.wdata <= '0;
            mem_req.write <= 1'b0;
        end
        if (fill_done) begin
            tags[fill_view.index] <= fill_view.tag;
            data[fill_view.index] <= mem_rdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= S_IDLE;
            valid     <= '0;
            read_data <= '0;
            hit       <= 1'b0;
            miss      <= 1'b0;
            done      <= 1'b0;
        end else begin
            hit  <= 1'b0;
            miss <= 1'b0;
            done <= 1'b0;

            // A local write below to the same line wins, being newer
            if (snoop_hit) begin
                valid[snoop_view.index] <= 1'b0;
            end

            case (state)
                S_IDLE: begin
                    if (write_enable) begin
                        valid[addr.index] <= 1'b1;
                        hit               <= lookup_hit;  // Rewrite of a live line
                        state             <= S_WT;
                    end else if (read_enable) begin
                        if (lookup_hit) begin
                            read_data <= data[addr.index];
                            hit       <= 1'b1;
                            done      <= 1'b1;
                        end else begin
                            read_data <= '0;
                            miss      <= 1'b1;
                            state     <= S_FILL;
                        end
                    end
                end
                S_FILL: begin
                    if (mem_ack) begin
                        valid[fill_view.index] <= 1'b1;
                        read_data              <= mem_rdata;
                        done                   <= 1'b1;
                        state                  <= S_IDLE;
                    end
                end
                S_WT: begin
                    if (mem_ack) begin
                        done  <= 1'b1;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

//--- hdl/mem_pkg.sv
//################################################
// Shared backing-store bus definitions
//################################################

package mem_pkg;

    localparam int ADDR_W    = 9;
    localparam int MEM_WORDS = 1 << ADDR_W;  // 512 words

    // One request on the shared bus, held steady while mem_want is high
    typedef struct packed {
        logic [ADDR_W-1:0]            addr;
        logic [cache_pkg::DATA_W-1:0] wdata;
        logic                         write;  // 0 for a line fill
    } mem_req_t;

endpackage

//--- hdl/cache_pkg.sv
//################################################
// Cache geometry and the client address view
// Import in any cache-side module
//################################################

package cache_pkg;

    // Line and word geometry, taken from the 9-bit client address
    localparam int TAG_W   = 4;
    localparam int INDEX_W = 5;
    localparam int DATA_W  = 12;
    localparam int N_LINES = 1 << INDEX_W;  // 32 lines

    // Client address as seen by a cache, tag above index
    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
    } cache_addr_t;

endpackage
